// ==== Makefile ====
# Verilator build and run of the miss tracker testbench

VERILATOR ?= verilator
TOP       ?= tb_miss_tracker
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
tracker_pkg.sv
lookup_if.sv
tag_directory.sv
miss_filter.sv
fill_retirer.sv
miss_tracker_top.sv
tb_clock_gen.sv
tb_miss_tracker.sv

// ==== fill_retirer.sv ====
// Fills must name an allocated slot; a merge at the same edge is counted before the clear
`timescale 1ns/10ps

module fill_retirer (
  input  logic                clock,
  input  logic                resetn,
  input  logic                merge_strobe,
  input  tracker_pkg::index_t merge_index,
  input  logic                fill_valid,
  input  tracker_pkg::index_t fill_index,
  output logic                evict_enable,
  output tracker_pkg::index_t evict_index,
  output logic                retire_valid,
  output tracker_pkg::index_t retire_index,
  output tracker_pkg::count_t retire_count
);

  // Merge counters per slot
  tracker_pkg::count_t counts      [tracker_pkg::DEPTH];
  tracker_pkg::count_t counts_next [tracker_pkg::DEPTH];

  // Counters after this cycle's merge, saturating at COUNT_MAX
  always_comb begin
    for (int i = 0; i < tracker_pkg::DEPTH; i++) begin
      counts_next[i] = counts[i];
      if (merge_strobe && merge_index == tracker_pkg::index_t'(i)
          && counts[i] != tracker_pkg::COUNT_MAX) begin
        counts_next[i] = counts[i] + 1'b1;
      end
    end
  end

  // Fill frees the slot in the directory at this same edge
  assign evict_enable = fill_valid;
  assign evict_index  = fill_index;

  // Counter update and retirement report
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      for (int i = 0; i < tracker_pkg::DEPTH; i++) begin
        counts[i] <= '0;
      end
      retire_valid <= 1'b0;
      retire_index <= '0;
      retire_count <= '0;
    end else begin
      for (int i = 0; i < tracker_pkg::DEPTH; i++) begin
        // Retired slot starts over empty
        if (fill_valid && fill_index == tracker_pkg::index_t'(i)) begin
          counts[i] <= '0;
        end else begin
          counts[i] <= counts_next[i];
        end
      end
      retire_valid <= fill_valid;
      if (fill_valid) begin
        retire_index <= fill_index;
        retire_count <= counts_next[fill_index];
      end
    end
  end

endmodule

// ==== lookup_if.sv ====
// Search is combinational in the same cycle, an allocation lands at the next rising edge
`timescale 1ns/10ps

interface lookup_if;

  // Allocation request toward the directory
  logic               alloc_enable;
  tracker_pkg::tag_t  alloc_tag;

  // Tag searched this cycle
  tracker_pkg::tag_t  search_tag;

  // Search answer, valid in the same cycle
  logic               search_hit;
  tracker_pkg::index_t search_index;

  // Lowest free slot and registered full flag
  tracker_pkg::index_t free_index;
  logic               full;

  // Miss filter side
  modport filter (
    output alloc_enable, alloc_tag, search_tag,
    input  search_hit, search_index, free_index, full
  );

  // Tag directory side
  modport directory (
    input  alloc_enable, alloc_tag, search_tag,
    output search_hit, search_index, free_index, full
  );

endinterface

// ==== miss_filter.sv ====
// One outcome per lookup, one cycle later; a full directory rejects new tags and drops them
`timescale 1ns/10ps

module miss_filter (
  input  logic                clock,
  input  logic                resetn,
  input  logic                lookup_valid,
  input  tracker_pkg::tag_t   lookup_tag,
  lookup_if.filter            lu,
  output logic                miss_valid,
  output tracker_pkg::index_t miss_index,
  output logic                merge_valid,
  output tracker_pkg::index_t merge_index,
  output logic                reject_valid,
  output logic                merge_strobe
);

  // Outcome of this cycle's lookup
  logic lookup_hit;
  logic lookup_miss;
  logic lookup_reject;

  // Same tag feeds both the search and a possible allocation
  assign lu.search_tag = lookup_tag;
  assign lu.alloc_tag  = lookup_tag;

  // Classify the lookup against the directory
  assign lookup_hit    = lookup_valid && lu.search_hit;
  assign lookup_miss   = lookup_valid && !lu.search_hit && !lu.full;
  assign lookup_reject = lookup_valid && !lu.search_hit && lu.full;

  // New miss claims the lowest free slot at this edge
  assign lu.alloc_enable = lookup_miss;

  // Hit pulse for the merge counters, same cycle
  assign merge_strobe = lookup_hit;

  // Registered outcome pulses
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      miss_valid   <= 1'b0;
      miss_index   <= '0;
      merge_valid  <= 1'b0;
      merge_index  <= '0;
      reject_valid <= 1'b0;
    end else begin
      miss_valid   <= lookup_miss;
      merge_valid  <= lookup_hit;
      reject_valid <= lookup_reject;
      // Indices only move with their pulse
      if (lookup_miss) begin
        miss_index <= lu.free_index;
      end
      if (lookup_hit) begin
        merge_index <= lu.search_index;
      end
    end
  end

  // Tag allocated at one edge is found by a repeat lookup at the next
  alloc_visible_next: assert property (
    @(posedge clock) disable iff (!resetn)
    ($past(lu.alloc_enable) && lookup_valid && lookup_tag == $past(lookup_tag))
      |-> lu.search_hit
  ) else $error("tag allocated last cycle was not found");

endmodule

// ==== miss_tracker_top.sv ====
// Plain strobes without handshake; outcomes and retirements arrive one cycle after their input
`timescale 1ns/10ps

module miss_tracker_top (
  input  logic                clock,
  input  logic                resetn,
  // Lookup request
  input  logic                lookup_valid,
  input  tracker_pkg::tag_t   lookup_tag,
  // Fill return
  input  logic                fill_valid,
  input  tracker_pkg::index_t fill_index,
  // Lookup outcomes
  output logic                miss_valid,
  output tracker_pkg::index_t miss_index,
  output logic                merge_valid,
  output tracker_pkg::index_t merge_index,
  output logic                reject_valid,
  output logic                full,
  // Retirement report
  output logic                retire_valid,
  output tracker_pkg::index_t retire_index,
  output tracker_pkg::count_t retire_count
);

  // Filter to directory link
  lookup_if lu ();

  // Retirer to directory eviction
  logic                evict_enable;
  tracker_pkg::index_t evict_index;

  // Filter hit pulse toward the counters
  logic                merge_strobe;

  // Directory full flag seen from outside
  assign full = lu.full;

  tag_directory u_tag_directory (
    .clock        (clock),
    .resetn       (resetn),
    .lu           (lu),
    .evict_enable (evict_enable),
    .evict_index  (evict_index)
  );

  miss_filter u_miss_filter (
    .clock        (clock),
    .resetn       (resetn),
    .lookup_valid (lookup_valid),
    .lookup_tag   (lookup_tag),
    .lu           (lu),
    .miss_valid   (miss_valid),
    .miss_index   (miss_index),
    .merge_valid  (merge_valid),
    .merge_index  (merge_index),
    .reject_valid (reject_valid),
    .merge_strobe (merge_strobe)
  );

  // Hit slot comes straight from the search so it lines up with merge_strobe
  fill_retirer u_fill_retirer (
    .clock        (clock),
    .resetn       (resetn),
    .merge_strobe (merge_strobe),
    .merge_index  (lu.search_index),
    .fill_valid   (fill_valid),
    .fill_index   (fill_index),
    .evict_enable (evict_enable),
    .evict_index  (evict_index),
    .retire_valid (retire_valid),
    .retire_index (retire_index),
    .retire_count (retire_count)
  );

endmodule

// ==== tag_directory.sv ====
// Allocation is ignored while full, and evictions must name a valid slot other than free_index
`timescale 1ns/10ps

module tag_directory (
  input  logic                clock,
  input  logic                resetn,
  lookup_if.directory         lu,
  input  logic                evict_enable,
  input  tracker_pkg::index_t evict_index
);

  // Stored tags, meaningful only where the valid bit is set
  tracker_pkg::tag_t tags [tracker_pkg::DEPTH];

  // Occupancy per slot
  logic [tracker_pkg::DEPTH-1:0] valid;
  logic [tracker_pkg::DEPTH-1:0] valid_next;

  // Write strobe for the tag array
  logic alloc_fire;

  // Lowest free slot
  // Scan downward so the lowest index wins without an early exit
  always_comb begin
    lu.free_index = '0;
    for (int i = tracker_pkg::DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        lu.free_index = tracker_pkg::index_t'(i);
      end
    end
  end

  // Associative search
  // Lowest matching valid slot is reported
  always_comb begin
    lu.search_hit   = 1'b0;
    lu.search_index = '0;
    for (int i = tracker_pkg::DEPTH - 1; i >= 0; i--) begin
      if (valid[i] && tags[i] == lu.search_tag) begin
        lu.search_hit   = 1'b1;
        lu.search_index = tracker_pkg::index_t'(i);
      end
    end
  end

  // Allocation only goes through with room left
  assign alloc_fire = lu.alloc_enable && !lu.full;

  // Next occupancy after allocation and eviction
  // Both never name the same slot since free_index is never valid
  always_comb begin
    valid_next = valid;
    if (alloc_fire) begin
      valid_next[lu.free_index] = 1'b1;
    end
    if (evict_enable) begin
      valid_next[evict_index] = 1'b0;
    end
  end

  // Valid bits and full flag
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      valid   <= '0;
      lu.full <= 1'b0;
    end else begin
      valid   <= valid_next;
      // Full tracks the slot state after this edge
      lu.full <= &valid_next;
    end
  end

  // Tag storage
  always_ff @(posedge clock) begin
    if (alloc_fire) begin
      tags[lu.free_index] <= lu.alloc_tag;
    end
  end

  // Fill retirer must only evict slots that hold a pending miss
  evict_names_valid_slot: assert property (
    @(posedge clock) disable iff (!resetn)
    evict_enable |-> valid[evict_index]
  ) else $error("eviction of free slot %0d", evict_index);

  // Miss filter must hold off allocation once the directory is full
  no_alloc_when_full: assert property (
    @(posedge clock) disable iff (!resetn)
    lu.alloc_enable |-> !lu.full
  ) else $error("allocation requested while full");

endmodule

// ==== tb_clock_gen.sv ====
// Free-running 10 ns clock; resetn is held low for 16 rising edges and released 1 ns after the last
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clock,
  output logic resetn
);

  // Half of the 10 ns period
  localparam int HALF_PERIOD = 5;

  // Rising edges spent in reset
  localparam int RESET_CYCLES = 16;

  initial begin
    clock = 1'b0;
    forever begin
      #HALF_PERIOD clock = ~clock;
    end
  end

  // Release away from the edge so no flop sees it at the same instant
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 resetn = 1'b1;
  end

endmodule

// ==== tb_miss_tracker.sv ====
// Inputs change 1 ns after each rising edge; outputs are checked 5 ns after the edge that samples them
`timescale 1ns/10ps

module tb_miss_tracker;

  // Run limits
  localparam int RANDOM_CYCLES = 3000;
  localparam int WATCHDOG_CYCLES = 20000;
  localparam int WAIT_LIMIT = 100;
  localparam int MAX_MERGES = 15;
  localparam logic [31:0] SEED = 32'h3bd9_3fde;

  // One expected output set per sampled input cycle
  typedef struct packed {
    logic                miss_valid;
    tracker_pkg::index_t miss_index;
    logic                merge_valid;
    tracker_pkg::index_t merge_index;
    logic                reject_valid;
    logic                full;
    logic                retire_valid;
    tracker_pkg::index_t retire_index;
    tracker_pkg::count_t retire_count;
  } expect_t;

  logic                clock;
  logic                resetn;
  logic                lookup_valid;
  tracker_pkg::tag_t   lookup_tag;
  logic                fill_valid;
  tracker_pkg::index_t fill_index;
  logic                miss_valid;
  tracker_pkg::index_t miss_index;
  logic                merge_valid;
  tracker_pkg::index_t merge_index;
  logic                reject_valid;
  logic                full;
  logic                retire_valid;
  tracker_pkg::index_t retire_index;
  tracker_pkg::count_t retire_count;

  // Reference directory state
  logic              m_valid [tracker_pkg::DEPTH];
  tracker_pkg::tag_t m_tag   [tracker_pkg::DEPTH];
  int                m_count [tracker_pkg::DEPTH];

  // Expectations waiting for their sampling edge
  expect_t exp_queue [$];

  int mismatch_count = 0;
  int other_errors = 0;

  tb_clock_gen u_clock_gen (
    .clock  (clock),
    .resetn (resetn)
  );

  miss_tracker_top u_miss_tracker_top (
    .clock        (clock),
    .resetn       (resetn),
    .lookup_valid (lookup_valid),
    .lookup_tag   (lookup_tag),
    .fill_valid   (fill_valid),
    .fill_index   (fill_index),
    .miss_valid   (miss_valid),
    .miss_index   (miss_index),
    .merge_valid  (merge_valid),
    .merge_index  (merge_index),
    .reject_valid (reject_valid),
    .full         (full),
    .retire_valid (retire_valid),
    .retire_index (retire_index),
    .retire_count (retire_count)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // Reference model, one sampled edge per call
  // Search and full use the state before the edge, fill retires after the merge
  function automatic expect_t model_step(input logic lv, input tracker_pkg::tag_t tag,
                                         input logic fv, input tracker_pkg::index_t fi);
    expect_t e;
    int hit_slot;
    int free_slot;
    int n_valid;
    e = '0;
    hit_slot = -1;
    free_slot = -1;
    n_valid = 0;
    for (int s = 0; s < tracker_pkg::DEPTH; s++) begin
      if (m_valid[s]) begin
        n_valid++;
        if (hit_slot < 0 && m_tag[s] == tag) begin
          hit_slot = s;
        end
      end else if (free_slot < 0) begin
        free_slot = s;
      end
    end
    if (lv) begin
      if (hit_slot >= 0) begin
        e.merge_valid = 1'b1;
        e.merge_index = tracker_pkg::index_t'(hit_slot);
        if (m_count[hit_slot] < MAX_MERGES) begin
          m_count[hit_slot]++;
        end
      end else if (n_valid < tracker_pkg::DEPTH) begin
        e.miss_valid = 1'b1;
        e.miss_index = tracker_pkg::index_t'(free_slot);
        m_valid[free_slot] = 1'b1;
        m_tag[free_slot] = tag;
      end else begin
        e.reject_valid = 1'b1;
      end
    end
    if (fv) begin
      e.retire_valid = 1'b1;
      e.retire_index = fi;
      e.retire_count = tracker_pkg::count_t'(m_count[fi]);
      m_count[fi] = 0;
      m_valid[fi] = 1'b0;
    end
    // Full after the edge
    e.full = 1'b1;
    for (int s = 0; s < tracker_pkg::DEPTH; s++) begin
      if (!m_valid[s]) begin
        e.full = 1'b0;
      end
    end
    return e;
  endfunction

  // One input cycle, sampled at the following edge
  task automatic drive_cycle(input logic lv, input tracker_pkg::tag_t tag,
                             input logic fv, input tracker_pkg::index_t fi);
    @(posedge clock);
    #1;
    lookup_valid = lv;
    lookup_tag = tag;
    fill_valid = fv;
    fill_index = fi;
    exp_queue.push_back(model_step(lv, tag, fv, fi));
  endtask

  task automatic lookup(input tracker_pkg::tag_t tag);
    drive_cycle(1'b1, tag, 1'b0, '0);
  endtask

  task automatic idle();
    drive_cycle(1'b0, '0, 1'b0, '0);
  endtask

  // Fills only ever name slots the model holds as valid
  task automatic random_mix(input int cycles);
    logic lv;
    tracker_pkg::tag_t tag;
    logic fv;
    tracker_pkg::index_t fi;
    int n;
    int pick;
    for (int c = 0; c < cycles; c++) begin
      lv = ($urandom_range(3) != 0);
      // Sixteen tags over eight slots gives hits and rejects
      tag = tracker_pkg::tag_t'($urandom_range(15));
      fv = 1'b0;
      fi = '0;
      n = 0;
      for (int s = 0; s < tracker_pkg::DEPTH; s++) begin
        if (m_valid[s]) begin
          n++;
        end
      end
      if (n != 0 && $urandom_range(2) == 0) begin
        pick = $urandom_range(n - 1);
        for (int s = 0; s < tracker_pkg::DEPTH; s++) begin
          if (m_valid[s]) begin
            if (pick == 0) begin
              fv = 1'b1;
              fi = tracker_pkg::index_t'(s);
            end
            pick--;
          end
        end
      end
      drive_cycle(lv, tag, fv, fi);
    end
  endtask

  // Compare process, one expectation per edge
  initial begin : compare_outputs
    expect_t cur;
    forever begin
      @(posedge clock);
      if (exp_queue.size() != 0) begin
        cur = exp_queue.pop_front();
        #5;
        check_value("miss_valid", miss_valid, cur.miss_valid);
        check_value("merge_valid", merge_valid, cur.merge_valid);
        check_value("reject_valid", reject_valid, cur.reject_valid);
        check_value("full", full, cur.full);
        check_value("retire_valid", retire_valid, cur.retire_valid);
        if (cur.miss_valid) begin
          check_value("miss_index", miss_index, cur.miss_index);
        end
        if (cur.merge_valid) begin
          check_value("merge_index", merge_index, cur.merge_index);
        end
        if (cur.retire_valid) begin
          check_value("retire_index", retire_index, cur.retire_index);
          check_value("retire_count", retire_count, cur.retire_count);
        end
      end
    end
  end

  // Hard stop if the run never reaches its end
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < WATCHDOG_CYCLES) begin
      @(posedge clock);
      cycles++;
    end
    $display("Simulation did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : main
    int n;
    lookup_valid = 1'b0;
    lookup_tag = '0;
    fill_valid = 1'b0;
    fill_index = '0;
    for (int s = 0; s < tracker_pkg::DEPTH; s++) begin
      m_valid[s] = 1'b0;
      m_tag[s] = '0;
      m_count[s] = 0;
    end
    void'($urandom(SEED));

    n = 0;
    while (resetn !== 1'b1 && n < WAIT_LIMIT) begin
      @(posedge clock);
      n++;
    end
    if (resetn !== 1'b1) begin
      other_errors++;
      $display("Reset was not released within %0d cycles", WAIT_LIMIT);
    end

    // Everything quiet out of reset
    @(posedge clock);
    #5;
    check_value("miss_valid", miss_valid, 1'b0);
    check_value("miss_index", miss_index, '0);
    check_value("merge_valid", merge_valid, 1'b0);
    check_value("merge_index", merge_index, '0);
    check_value("reject_valid", reject_valid, 1'b0);
    check_value("full", full, 1'b0);
    check_value("retire_valid", retire_valid, 1'b0);
    check_value("retire_index", retire_index, '0);
    check_value("retire_count", retire_count, '0);

    // Distinct tags land in slots 0, 1, 2, then a repeat merges
    lookup(8'h10);
    lookup(8'h11);
    lookup(8'h12);
    lookup(8'h12);
    // Five more fill the directory
    for (int t = 8'h13; t <= 8'h17; t++) begin
      lookup(tracker_pkg::tag_t'(t));
    end
    lookup(8'h20);
    lookup(8'h14);
    idle();

    // Slot 5 saturates, last merge shares the edge with its fill
    repeat (17) lookup(8'h15);
    drive_cycle(1'b1, 8'h15, 1'b1, 3'd5);
    lookup(8'h11);
    lookup(8'h11);
    drive_cycle(1'b1, 8'h11, 1'b1, 3'd1);
    // Evicted tag misses again in the lowest free slot
    lookup(8'h11);
    lookup(8'h30);
    drive_cycle(1'b0, '0, 1'b1, 3'd0);
    lookup(8'h40);
    idle();

    random_mix(RANDOM_CYCLES);
    idle();

    n = 0;
    while (exp_queue.size() != 0 && n < WAIT_LIMIT) begin
      @(posedge clock);
      n++;
    end
    if (exp_queue.size() != 0) begin
      other_errors++;
      $display("Expected outputs were still pending after %0d cycles", WAIT_LIMIT);
    end
    #6;

    $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== tracker_pkg.sv ====
// Shared sizes for the tracker where DEPTH must equal 2**INDEX_WIDTH and merge counts saturate
package tracker_pkg;

  // Bits in a lookup tag
  localparam int TAG_WIDTH = 8;

  // Slots in the tag directory
  localparam int DEPTH = 8;

  // Bits needed to name one slot
  localparam int INDEX_WIDTH = 3;

  // Bits in a per-slot merge counter
  localparam int COUNT_WIDTH = 4;

  // Tag as seen on the lookup port
  typedef logic [TAG_WIDTH-1:0] tag_t;

  // Slot number inside the directory
  typedef logic [INDEX_WIDTH-1:0] index_t;

  // Number of lookups merged into a slot
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // Saturation point of the merge counter, 15 for 4 bits
  localparam count_t COUNT_MAX = '1;

endpackage
